/* src/ppu_defines.svh */
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// ================================================
// Tile geometry
// ================================================

// Rows per tile and spike bits per row
`define PPU_ROWS        16
`define PPU_SPIKES      16

// Row id and popcount widths
`define PPU_ROW_W       4
`define PPU_PC_W        5

// Each detector bank covers half the tile
`define PPU_BANK_ROWS   8

// ================================================
// Pipeline
// ================================================

// Query to task latency in clocks
`define PPU_PIPE_DEPTH  2

`endif

/* src/ppu_tile_pkg.sv */
`include "ppu_defines.svh"

package ppu_tile_pkg;

  // Basic field types
  typedef logic [`PPU_ROW_W-1:0]  row_id_t;
  typedef logic [`PPU_SPIKES-1:0] pattern_t;
  typedef logic [`PPU_PC_W-1:0]   popcnt_t;

  // One stored row
  // Popcount is derived from the pattern on write
  typedef struct packed {
    pattern_t pattern;
    popcnt_t  popcount;
  } tile_row_t;

  // One query, issued once per clock during the sweep
  typedef struct packed {
    logic     valid;
    row_id_t  row_id;
    pattern_t pattern;
    // Final row of the tile
    logic     last;
  } query_t;

endpackage

/* src/ppu_task_pkg.sv */
`include "ppu_defines.svh"

package ppu_task_pkg;

  import ppu_tile_pkg::*;

  // ================================================
  // Bank result
  // ================================================

  // Query fields ride along so the merger needs no side path
  typedef struct packed {
    query_t   q;
    // At least one eligible prefix in this bank
    logic     found;
    row_id_t  best_id;
    popcnt_t  best_pc;
    pattern_t best_pattern;
  } cand_t;

  // ================================================
  // Dispatched task
  // ================================================

  typedef struct packed {
    row_id_t  row_id;
    logic     has_prefix;
    // Zero for a root row
    row_id_t  prefix_id;
    // Query XOR prefix, or the query itself for a root
    pattern_t residual;
    popcnt_t  res_pc;
  } task_t;

endpackage

/* src/tile_store.sv */
`timescale 1ns/1ps
`include "ppu_defines.svh"

module tile_store
  import ppu_tile_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  // Host write port
  input  logic                         tile_wr_en,
  input  row_id_t                      tile_wr_addr,
  input  pattern_t                     tile_wr_pattern,
  // Sweep in progress freezes the table
  input  logic                         busy,
  // Query request from the sequencer
  input  row_id_t                      query_row,
  input  logic                         query_valid,
  input  logic                         query_last,
  // Whole table to the detectors
  output tile_row_t [`PPU_ROWS-1:0]    row_table,
  output query_t                       query
);

  // ================================================
  // Row registers
  // ================================================

  logic wr_accept;

  // Host writes only land between tiles
  assign wr_accept = tile_wr_en && !busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_table <= '0;
    end else if (wr_accept) begin
      // Popcount derived from the written pattern
      row_table[tile_wr_addr] <= '{
        pattern:  tile_wr_pattern,
        popcount: popcnt_t'($countones(tile_wr_pattern))
      };
    end
  end

  // ================================================
  // Query assembly
  // ================================================

  // Same cycle read that the detectors register
  always_comb begin
    query.valid   = query_valid;
    query.row_id  = query_row;
    query.pattern = row_table[query_row].pattern;
    query.last    = query_last;
  end

  // Table stays frozen while queries are in flight
  a_table_frozen : assert property (
    @(posedge clk) disable iff (!rst_n)
    query_valid |=> $stable(row_table)
  ) else $error("tile_store: table changed during the sweep");

endmodule

/* src/tile_sequencer.sv */
`timescale 1ns/1ps
`include "ppu_defines.svh"

module tile_sequencer
  import ppu_tile_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    tile_start,
  output logic    busy,
  output row_id_t query_row,
  output logic    query_valid,
  output logic    query_last
);

  // ================================================
  // State and counters
  // ================================================

  typedef enum logic [1:0] {
    st_idle,
    st_sweep,
    st_drain
  } state_t;

  localparam int drain_w = $clog2(`PPU_PIPE_DEPTH + 1);

  // Terminal counts
  localparam row_id_t               row_last   = row_id_t'(`PPU_ROWS - 1);
  localparam logic [drain_w-1:0]    drain_last = drain_w'(`PPU_PIPE_DEPTH - 1);

  state_t             state;
  state_t             state_nxt;
  row_id_t            row_cnt;
  logic [drain_w-1:0] drain_cnt;

  // Next state
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        // Start only honoured when idle
        if (tile_start) begin
          state_nxt = st_sweep;
        end
      end
      st_sweep: begin
        if (row_cnt == row_last) begin
          state_nxt = st_drain;
        end
      end
      st_drain: begin
        // Wait for the last query to leave the pipeline
        if (drain_cnt == drain_last) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      row_cnt   <= '0;
      drain_cnt <= '0;
    end else begin
      state <= state_nxt;
      case (state)
        st_idle: begin
          row_cnt   <= '0;
          drain_cnt <= '0;
        end
        // One row per clock with a wrap to zero after the last row
        st_sweep: row_cnt <= row_cnt + 1'b1;
        st_drain: drain_cnt <= drain_cnt + 1'b1;
        default: row_cnt <= '0;
      endcase
    end
  end

  // ================================================
  // Outputs
  // ================================================

  assign busy        = (state != st_idle);
  assign query_valid = (state == st_sweep);
  assign query_row   = row_cnt;
  assign query_last  = query_valid && (row_cnt == row_last);

  // A sweep opens at row 0 and only right after a start
  a_sweep_start : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(query_valid) |-> (query_row == '0) && $past(tile_start)
  ) else $error("tile_sequencer: query issued outside a started sweep");

  // Busy covers the last query plus the pipeline drain
  a_drain_length : assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> $past(query_last, `PPU_PIPE_DEPTH + 1)
  ) else $error("tile_sequencer: drain length does not match the pipeline depth");

endmodule

/* src/subset_detector.sv */
`timescale 1ns/1ps
`include "ppu_defines.svh"

module subset_detector
  import ppu_tile_pkg::*;
  import ppu_task_pkg::*;
#(
  // Global index of entry 0 of this bank
  parameter int BANK_BASE = 0
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  query_t                         query,
  input  tile_row_t [`PPU_BANK_ROWS-1:0] bank_rows,
  output cand_t                          cand
);

  // ================================================
  // Ternary match
  // ================================================

  logic [`PPU_BANK_ROWS-1:0] eligible;
  logic                      found;
  row_id_t                   best_id;
  popcnt_t                   best_pc;
  pattern_t                  best_pat;
  cand_t                     cand_d;

  always_comb begin
    found    = 1'b0;
    best_id  = '0;
    best_pc  = '0;
    best_pat = '0;
    for (int k = 0; k < `PPU_BANK_ROWS; k++) begin
      // Earlier row, nonzero, and no bit outside the query
      eligible[k] = ((BANK_BASE + k) < int'(query.row_id)) &&
                    (|bank_rows[k].pattern) &&
                    ((bank_rows[k].pattern & ~query.pattern) == '0);
      // Ascending scan with strict compare keeps the lowest index on a tie
      if (eligible[k] && (!found || (bank_rows[k].popcount > best_pc))) begin
        found    = 1'b1;
        best_id  = row_id_t'(BANK_BASE + k);
        best_pc  = bank_rows[k].popcount;
        best_pat = bank_rows[k].pattern;
      end
    end
  end

  // ================================================
  // Candidate register
  // ================================================

  // Query fields travel with the result
  always_comb begin
    cand_d.q            = query;
    cand_d.found        = found;
    cand_d.best_id      = best_id;
    cand_d.best_pc      = best_pc;
    cand_d.best_pattern = best_pat;
  end

  // Only the valid bit needs a reset value
  always_ff @(posedge clk) begin
    cand <= cand_d;
    if (!rst_n) begin
      cand.q.valid <= 1'b0;
    end
  end

endmodule

/* src/prefix_merger.sv */
`timescale 1ns/1ps
`include "ppu_defines.svh"

module prefix_merger
  import ppu_tile_pkg::*;
  import ppu_task_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  // Low bank holds rows 0..7, high bank rows 8..15
  input  cand_t cand_lo,
  input  cand_t cand_hi,
  output logic  task_valid,
  output task_t task_data,
  output logic  tile_done
);

  // ================================================
  // Bank selection
  // ================================================

  logic     take_hi;
  logic     has_prefix;
  cand_t    chosen;
  pattern_t residual;
  task_t    task_d;

  // High bank wins only on a strictly larger popcount
  // Ties stay in the low bank, which has the lower indices
  assign take_hi    = cand_hi.found && (!cand_lo.found || (cand_hi.best_pc > cand_lo.best_pc));
  assign has_prefix = cand_lo.found || cand_hi.found;
  assign chosen     = take_hi ? cand_hi : cand_lo;

  // ================================================
  // Residual and task word
  // ================================================

  // Root rows keep their own pattern
  assign residual = has_prefix ? (cand_lo.q.pattern ^ chosen.best_pattern)
                               : cand_lo.q.pattern;

  always_comb begin
    task_d.row_id     = cand_lo.q.row_id;
    task_d.has_prefix = has_prefix;
    task_d.prefix_id  = has_prefix ? chosen.best_id : '0;
    task_d.residual   = residual;
    task_d.res_pc     = popcnt_t'($countones(residual));
  end

  // Payload without reset, strobes cleared
  always_ff @(posedge clk) begin
    task_data <= task_d;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      task_valid <= 1'b0;
      tile_done  <= 1'b0;
    end else begin
      task_valid <= cand_lo.q.valid;
      // Done rides on the final task of the tile
      tile_done  <= cand_lo.q.valid && cand_lo.q.last;
    end
  end

  // Both detectors must be working on the same query
  a_banks_aligned : assert property (
    @(posedge clk) disable iff (!rst_n)
    cand_lo.q.valid |-> cand_hi.q.valid && (cand_hi.q.row_id == cand_lo.q.row_id)
  ) else $error("prefix_merger: bank candidates out of step");

endmodule

/* src/ppu_top.sv */
`timescale 1ns/1ps
`include "ppu_defines.svh"

module ppu_top
  import ppu_tile_pkg::*;
  import ppu_task_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // Host row writes
  input  logic     tile_wr_en,
  input  row_id_t  tile_wr_addr,
  input  pattern_t tile_wr_pattern,
  // Sweep control
  input  logic     tile_start,
  output logic     busy,
  // Task stream, one per clock, no back-pressure
  output logic     task_valid,
  output task_t    task_data,
  output logic     tile_done
);

  // ================================================
  // Internal nets
  // ================================================

  tile_row_t [`PPU_ROWS-1:0] row_table;
  query_t                    query;
  row_id_t                   query_row;
  logic                      query_valid;
  logic                      query_last;
  cand_t                     cand_lo;
  cand_t                     cand_hi;

  // Row storage and query read
  tile_store u_tile_store (
    .clk             (clk),
    .rst_n           (rst_n),
    .tile_wr_en      (tile_wr_en),
    .tile_wr_addr    (tile_wr_addr),
    .tile_wr_pattern (tile_wr_pattern),
    .busy            (busy),
    .query_row       (query_row),
    .query_valid     (query_valid),
    .query_last      (query_last),
    .row_table       (row_table),
    .query           (query)
  );

  // Row sweep control
  tile_sequencer u_tile_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .tile_start  (tile_start),
    .busy        (busy),
    .query_row   (query_row),
    .query_valid (query_valid),
    .query_last  (query_last)
  );

  // ================================================
  // Detector banks
  // ================================================

  // Low half of the table
  subset_detector #(.BANK_BASE(0)) u_det_lo (
    .clk       (clk),
    .rst_n     (rst_n),
    .query     (query),
    .bank_rows (row_table[`PPU_BANK_ROWS-1:0]),
    .cand      (cand_lo)
  );

  // High half of the table
  subset_detector #(.BANK_BASE(`PPU_BANK_ROWS)) u_det_hi (
    .clk       (clk),
    .rst_n     (rst_n),
    .query     (query),
    .bank_rows (row_table[`PPU_ROWS-1:`PPU_BANK_ROWS]),
    .cand      (cand_hi)
  );

  // Final selection and task register
  prefix_merger u_prefix_merger (
    .clk        (clk),
    .rst_n      (rst_n),
    .cand_lo    (cand_lo),
    .cand_hi    (cand_hi),
    .task_valid (task_valid),
    .task_data  (task_data),
    .tile_done  (tile_done)
  );

  // Every query turns into a task after the fixed pipeline delay
  a_pipe_latency : assert property (
    @(posedge clk) disable iff (!rst_n)
    query_valid |-> ## `PPU_PIPE_DEPTH task_valid
  ) else $error("ppu_top: task missing after query");

  // Busy drops right after the last task
  a_idle_after_done : assert property (
    @(posedge clk) disable iff (!rst_n)
    tile_done |=> !busy
  ) else $error("ppu_top: busy held after tile_done");

endmodule

/* verification/ppu_tb.sv */
`timescale 1ns/1ps
`include "ppu_defines.svh"

module ppu_tb
  import ppu_tile_pkg::*;
  import ppu_task_pkg::*;
();

  localparam int rows            = `PPU_ROWS;
  localparam int pipe_depth      = `PPU_PIPE_DEPTH;
  // Empty table, directed, directed again, then random rewrites
  localparam int num_tiles       = 7;
  localparam int watchdog_cycles = num_tiles * (rows + 8) + 200;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     tile_wr_en;
  row_id_t  tile_wr_addr;
  pattern_t tile_wr_pattern;
  logic     tile_start;
  logic     busy;
  logic     task_valid;
  task_t    task_data;
  logic     tile_done;

  // Shadow of the row table holding only accepted writes
  pattern_t    shadow [rows];
  logic [15:0] lfsr;
  int          cycle = 0;
  int          start_cycle;
  int          tasks_seen;
  logic        done_prev;

  ppu_top dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .tile_wr_en      (tile_wr_en),
    .tile_wr_addr    (tile_wr_addr),
    .tile_wr_pattern (tile_wr_pattern),
    .tile_start      (tile_start),
    .busy            (busy),
    .task_valid      (task_valid),
    .task_data       (task_data),
    .tile_done       (tile_done)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // Posedge count read on the falling edge
  always @(posedge clk) cycle <= cycle + 1;

  // ================================================
  // Random source and reference model
  // ================================================

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[14:0], lfsr[0]};
    end
  endtask

  function automatic int count_bits(input pattern_t p);
    int n;
    n = 0;
    for (int i = 0; i < `PPU_SPIKES; i++) begin
      n += int'(p[0]);
      p = p >> 1;
    end
    return n;
  endfunction

  // Best earlier nonzero subset by popcount with the lowest index on a tie
  function automatic task_t expected_task(input int row);
    task_t    t;
    pattern_t q;
    int       best;
    int       best_pc;
    q       = shadow[row];
    best    = -1;
    best_pc = -1;
    for (int j = 0; j < row; j++) begin
      if (shadow[j] != '0 && (shadow[j] & ~q) == '0 && count_bits(shadow[j]) > best_pc) begin
        best    = j;
        best_pc = count_bits(shadow[j]);
      end
    end
    t.row_id     = row_id_t'(row);
    t.has_prefix = (best >= 0);
    t.prefix_id  = (best >= 0) ? row_id_t'(best) : '0;
    t.residual   = (best >= 0) ? (q ^ shadow[best]) : q;
    t.res_pc     = popcnt_t'(count_bits(t.residual));
    return t;
  endfunction

  // Hand-built table for roots, multi-bank prefixes and ties
  function automatic pattern_t directed_pattern(input int row);
    case (row)
      0:       return 16'h00F0;
      1:       return 16'h0030;  // subset of row 0 and still a root
      2:       return 16'h0000;  // zero row is never a prefix
      3:       return 16'h0010;
      4:       return 16'h00F3;  // row 0 beats rows 1 and 3
      5:       return 16'h0F00;
      6:       return 16'h0C00;
      7:       return 16'h0300;
      8:       return 16'h0FF0;  // rows 0 and 5 tie inside the low bank
      9:       return 16'h0F00;  // duplicate of row 5 with zero residual
      10:      return 16'h3000;
      11:      return 16'h3F00;  // row 5 and row 9 tie across banks
      12:      return 16'hFFF0;  // row 8 in the high bank wins
      13:      return 16'h8001;
      14:      return 16'h0033;
      default: return 16'hFFFF;
    endcase
  endfunction

  // ================================================
  // Failure reporting
  // ================================================

  task automatic report_value(input string name, input int got, input int want);
    $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
    $display("TESTS FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("%s at %0t ns", what, $time);
    $display("TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  // ================================================
  // Stimulus tasks entered and left on a falling edge
  // ================================================

  task automatic write_row(input int addr, input pattern_t pat, input logic accepted);
    tile_wr_en      = 1'b1;
    tile_wr_addr    = row_id_t'(addr);
    tile_wr_pattern = pat;
    if (accepted) begin
      shadow[addr] = pat;
    end
    @(negedge clk);
    tile_wr_en = 1'b0;
  endtask

  task automatic load_directed();
    for (int i = 0; i < rows; i++) begin
      write_row(i, directed_pattern(i), 1'b1);
    end
  endtask

  // Mix of random rows, subsets and supersets of stored rows
  task automatic rewrite_random(input int count);
    logic [15:0] addr;
    logic [15:0] mode;
    logic [15:0] src;
    logic [15:0] pat;
    for (int i = 0; i < count; i++) begin
      take_bits(4, addr);
      take_bits(2, mode);
      take_bits(4, src);
      take_bits(16, pat);
      if (mode[1:0] == 2'd1) begin
        pat = pat & shadow[src[3:0]];
      end else if (mode[1]) begin
        // Stored row plus a few extra spikes
        pat = shadow[src[3:0]] | (pat & (pat >> 3));
      end
      write_row(int'(addr[3:0]), pat, 1'b1);
    end
  endtask

  task automatic run_tile(input logic disturb);
    tile_start  = 1'b1;
    start_cycle = cycle + 1;
    tasks_seen  = 0;
    @(negedge clk);
    tile_start = 1'b0;
    assert (busy) else report_failure("busy did not rise after tile_start");
    if (disturb) begin
      repeat (3) @(negedge clk);
      // Table is frozen mid sweep
      write_row(4, 16'hFFFF, 1'b0);
      write_row(15, 16'h0001, 1'b0);
      // Second start while busy
      tile_start = 1'b1;
      @(negedge clk);
      tile_start = 1'b0;
    end
    wait (tasks_seen == rows);
    @(negedge clk);
    // Quiet gap where any stray task trips the checker
    repeat (3) @(negedge clk);
  endtask

  // ================================================
  // Task checker
  // ================================================

  always @(negedge clk) begin : check_tasks
    task_t want;
    if (rst_n) begin
      if (done_prev) begin
        assert (!busy) else report_failure("busy still high the cycle after tile_done");
      end
      done_prev = tile_done;
      if (task_valid) begin
        assert (tasks_seen < rows) else report_failure("task issued after the last row");
        assert (cycle == start_cycle + pipe_depth + tasks_seen)
          else report_value("task_valid cycle", cycle, start_cycle + pipe_depth + tasks_seen);
        want = expected_task(tasks_seen);
        assert (task_data.row_id == want.row_id)
          else report_value("task_data.row_id", int'(task_data.row_id), int'(want.row_id));
        assert (task_data.has_prefix == want.has_prefix)
          else report_value("task_data.has_prefix", int'(task_data.has_prefix),
                            int'(want.has_prefix));
        assert (task_data.prefix_id == want.prefix_id)
          else report_value("task_data.prefix_id", int'(task_data.prefix_id),
                            int'(want.prefix_id));
        assert (task_data.residual == want.residual)
          else report_value("task_data.residual", int'(task_data.residual),
                            int'(want.residual));
        assert (task_data.res_pc == want.res_pc)
          else report_value("task_data.res_pc", int'(task_data.res_pc), int'(want.res_pc));
        // Done only with row 15
        assert (tile_done == (tasks_seen == rows - 1))
          else report_value("tile_done", int'(tile_done), int'(tasks_seen == rows - 1));
        tasks_seen++;
      end else begin
        assert (!tile_done) else report_failure("tile_done raised without a task");
      end
    end
  end

  // ================================================
  // Main sequence and watchdog
  // ================================================

  initial begin : stimulus
    rst_n           = 1'b0;
    tile_wr_en      = 1'b0;
    tile_wr_addr    = '0;
    tile_wr_pattern = '0;
    tile_start      = 1'b0;
    lfsr            = 16'd2;
    start_cycle     = 0;
    tasks_seen      = 0;
    done_prev       = 1'b0;
    for (int i = 0; i < rows; i++) begin
      shadow[i] = '0;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    assert (!busy && !task_valid && !tile_done)
      else report_failure("control outputs not low after reset");
    // Cleared table where every row is a zero root
    run_tile(1'b0);
    load_directed();
    run_tile(1'b1);
    // Same table again without the dropped writes
    run_tile(1'b0);
    for (int t = 0; t < num_tiles - 3; t++) begin
      rewrite_random(8);
      run_tile(1'b0);
    end
    $display("TESTS PASSED");
    $finish;
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("run did not finish within %0d cycles, the DUT stopped issuing tasks",
             watchdog_cycles);
    $display("TESTS FAILED");
    $fatal(1, "timeout");
  end

endmodule

/* files.f */
+incdir+src
src/ppu_tile_pkg.sv
src/ppu_task_pkg.sv
src/tile_store.sv
src/tile_sequencer.sv
src/subset_detector.sv
src/prefix_merger.sv
src/ppu_top.sv
verification/ppu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the PPU testbench with Verilator, run it, and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module ppu_tb \
  -f files.f \
  -o ppu_sim

status=0
./obj_dir/ppu_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
